/* design/pov_geometry_pkg.sv */
`default_nettype none

package pov_geometry_pkg;

    // arm angle resolution, one full turn is 2**theta_width_p steps
    localparam int theta_width_p = 8;

    // 256 / phi, spreads successive scan indices over the turn
    localparam logic [7:0] fib_step_c = 8'd157;

    // phases below this are drawn, roughly 5/8 of the indices
    localparam logic [7:0] mask_threshold_c = 8'd160;

    // smallest cube half-size in pixels, grows with the angle quadrant
    localparam logic [3:0] cube_base_half_c = 4'd3;

    // top-level parameter defaults
    localparam int default_num_rows_c  = 16;
    localparam int default_num_cols_c  = 32;
    localparam int default_scan_rate_c = 16;   // half of the columns

endpackage

`default_nettype wire

/* design/pov_display_pkg.sv */
`default_nettype none

package pov_display_pkg;

    typedef enum logic {
        mode_boids = 1'b0,
        mode_cube  = 1'b1
    } display_mode_e;

    localparam int num_boids_c = 8;

    // 4-bit config address map
    localparam logic [3:0] cfg_addr_ctrl_c      = 4'd0;
    localparam logic [3:0] cfg_addr_boid_base_c = 4'd1;   // slots 0..7 at 1..8

    // one write word, decoded by address as control fields or a boid position
    typedef union packed {
        struct packed {
            logic [6:0]    rsvd;
            display_mode_e mode;
            logic [7:0]    theta_offset;
        } ctrl;
        struct packed {
            logic [1:0] rsvd_hi;
            logic       boid_en;
            logic [4:0] boid_col;
            logic [3:0] boid_row;
            logic [3:0] rsvd_lo;
        } boid;
    } cfg_word_u;

endpackage

`default_nettype wire

/* design/pov_config_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module pov_config_regs (
    input  logic                                                clk_in,
    input  logic                                                rst,
    input  logic                                                cfg_valid,
    input  logic [3:0]                                          cfg_addr,
    input  pov_display_pkg::cfg_word_u                          cfg_data,
    output pov_display_pkg::display_mode_e                      mode,
    output logic [7:0]                                          theta_offset,
    output logic [pov_display_pkg::num_boids_c-1:0]             boid_en,
    output logic [pov_display_pkg::num_boids_c-1:0][4:0]        boid_col,
    output logic [pov_display_pkg::num_boids_c-1:0][3:0]        boid_row
);
    import pov_display_pkg::*;

    logic                   ctrl_we;
    logic [num_boids_c-1:0] boid_we;   // one-hot slot write enable

    assign ctrl_we = cfg_valid && (cfg_addr == cfg_addr_ctrl_c);

    always_comb begin
        for (int s = 0; s < num_boids_c; s++) begin
            boid_we[s] = cfg_valid && (cfg_addr == 4'(cfg_addr_boid_base_c + s));
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            mode         <= mode_boids;
            theta_offset <= '0;
            boid_en      <= '0;
        end else begin
            if (ctrl_we) begin
                mode         <= cfg_data.ctrl.mode;
                theta_offset <= cfg_data.ctrl.theta_offset;
            end
            for (int s = 0; s < num_boids_c; s++) begin
                if (boid_we[s]) begin
                    boid_en[s] <= cfg_data.boid.boid_en;
                end
            end
        end
    end

    // slot position, written together with the slot enable
    always_ff @(posedge clk_in) begin
        for (int s = 0; s < num_boids_c; s++) begin
            if (boid_we[s]) begin
                boid_col[s] <= cfg_data.boid.boid_col;
                boid_row[s] <= cfg_data.boid.boid_row;
            end
        end
    end

endmodule

`default_nettype wire

/* design/scan_mask_calc.sv */
`timescale 1ns/100ps
`default_nettype none

module scan_mask_calc #(
    parameter int SCAN_RATE = 16
) (
    input  logic [pov_geometry_pkg::theta_width_p-1:0] eff_theta,
    output logic [SCAN_RATE-1:0]                       scan_mask
);
    import pov_geometry_pkg::*;

    logic [theta_width_p-1:0] phase [SCAN_RATE];   // per-index golden-ratio phase

    // index i is drawn when its phase lands in the lower part of the turn,
    // so consecutive angles pick out well spread subsets of the columns
    for (genvar i = 0; i < SCAN_RATE; i++) begin : g_idx
        assign phase[i]     = theta_width_p'(i * fib_step_c + eff_theta);   // wraps mod 256
        assign scan_mask[i] = (phase[i] < mask_threshold_c);
    end

endmodule

`default_nettype wire

/* design/cube_column_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module cube_column_gen #(
    parameter int NUM_ROWS = 16,
    parameter int NUM_COLS = 32
) (
    input  logic [pov_geometry_pkg::theta_width_p-1:0] eff_theta,
    input  logic [$clog2(NUM_COLS)-1:0]                col_num1,
    input  logic [$clog2(NUM_COLS)-1:0]                col_num2,
    output logic [NUM_ROWS-1:0]                        column_lo,
    output logic [NUM_ROWS-1:0]                        column_hi
);
    import pov_geometry_pkg::*;

    localparam int COL_W      = $clog2(NUM_COLS);
    localparam int CENTRE_COL = NUM_COLS / 2;
    localparam int CENTRE_ROW = NUM_ROWS / 2;

    logic [3:0] half;   // cube half-size, breathes with the quadrant

    function automatic logic [NUM_ROWS-1:0] draw_column(
        input logic [COL_W-1:0] col,
        input logic [3:0]       h
    );
        int                  d;
        int                  hh;
        logic [NUM_ROWS-1:0] word;
        hh   = int'(h);
        d    = (int'(col) >= CENTRE_COL) ? int'(col) - CENTRE_COL : CENTRE_COL - int'(col);
        word = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (d == hh) begin
                word[r] = (r >= CENTRE_ROW - hh) && (r <= CENTRE_ROW + hh);   // side edge
            end else if (d < hh) begin
                word[r] = (r == CENTRE_ROW - hh) || (r == CENTRE_ROW + hh);   // top and bottom
            end
        end
        return word;
    endfunction

    assign half      = cube_base_half_c + 4'(eff_theta[theta_width_p-1 -: 2]);
    assign column_lo = draw_column(col_num1, half);
    assign column_hi = draw_column(col_num2, half);

endmodule

`default_nettype wire

/* design/boids_column_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module boids_column_lookup #(
    parameter int NUM_ROWS = 16,
    parameter int NUM_COLS = 32
) (
    input  logic [$clog2(NUM_COLS)-1:0]                  col_num1,
    input  logic [$clog2(NUM_COLS)-1:0]                  col_num2,
    input  logic [pov_display_pkg::num_boids_c-1:0]      boid_en,
    input  logic [pov_display_pkg::num_boids_c-1:0][4:0] boid_col,
    input  logic [pov_display_pkg::num_boids_c-1:0][3:0] boid_row,
    output logic [NUM_ROWS-1:0]                          column_lo,
    output logic [NUM_ROWS-1:0]                          column_hi
);
    import pov_display_pkg::*;

    localparam int COL_W = $clog2(NUM_COLS);

    // all slots are matched in parallel, several boids may share a column
    function automatic logic [NUM_ROWS-1:0] light_column(
        input logic [COL_W-1:0]                  col,
        input logic [num_boids_c-1:0]            en,
        input logic [num_boids_c-1:0][4:0]       cols,
        input logic [num_boids_c-1:0][3:0]       rows
    );
        logic [NUM_ROWS-1:0] word;
        word = '0;
        for (int s = 0; s < num_boids_c; s++) begin
            if (en[s] && (int'(cols[s]) == int'(col)) && (int'(rows[s]) < NUM_ROWS)) begin
                word[rows[s]] = 1'b1;   // one-hot row bit per hit
            end
        end
        return word;
    endfunction

    assign column_lo = light_column(col_num1, boid_en, boid_col, boid_row);
    assign column_hi = light_column(col_num2, boid_en, boid_col, boid_row);

endmodule

`default_nettype wire

/* design/pov_frame_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module pov_frame_buffer #(
    parameter int NUM_ROWS  = 16,
    parameter int NUM_COLS  = 32,
    parameter int SCAN_RATE = 16
) (
    input  logic                                         clk_in,
    input  logic                                         rst,
    input  logic [pov_geometry_pkg::theta_width_p-1:0]   theta,
    input  pov_display_pkg::display_mode_e               mode,
    input  logic [pov_geometry_pkg::theta_width_p-1:0]   theta_offset,
    input  logic [pov_display_pkg::num_boids_c-1:0]      boid_en,
    input  logic [pov_display_pkg::num_boids_c-1:0][4:0] boid_col,
    input  logic [pov_display_pkg::num_boids_c-1:0][3:0] boid_row,
    input  logic                                         col_ready,
    output logic                                         col_valid,
    output logic [NUM_ROWS-1:0]                          column_lo,
    output logic [NUM_ROWS-1:0]                          column_hi,
    output logic [$clog2(NUM_COLS)-1:0]                  col_num1,
    output logic [$clog2(NUM_COLS)-1:0]                  col_num2
);
    import pov_geometry_pkg::*;
    import pov_display_pkg::*;

    localparam int COL_W = $clog2(NUM_COLS);
    localparam int IDX_W = $clog2(SCAN_RATE);

    logic [theta_width_p-1:0] eff_theta;
    logic [theta_width_p-1:0] last_theta;   // effective angle seen last cycle
    logic                     angle_changed;
    logic [IDX_W-1:0]         scan_idx;
    logic                     scan_done;
    logic                     advance;
    logic                     load;
    logic [SCAN_RATE-1:0]     scan_mask;
    logic [COL_W-1:0]         cur_num1;
    logic [COL_W-1:0]         cur_num2;
    logic [NUM_ROWS-1:0]      cube_lo, cube_hi;
    logic [NUM_ROWS-1:0]      boids_lo, boids_hi;

    assign eff_theta     = theta + theta_offset;   // wraps mod 256
    assign angle_changed = (eff_theta != last_theta);
    assign cur_num1      = COL_W'(scan_idx);
    assign cur_num2      = cur_num1 + COL_W'(SCAN_RATE);

    // step when the output slot is free or is being emptied this edge
    assign advance = !scan_done && (!col_valid || col_ready);
    assign load    = advance && scan_mask[scan_idx];

    scan_mask_calc #(.SCAN_RATE(SCAN_RATE)) scan_mask_calc_inst (
        .eff_theta (eff_theta),
        .scan_mask (scan_mask)
    );

    cube_column_gen #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) cube_column_gen_inst (
        .eff_theta (eff_theta),
        .col_num1  (cur_num1),
        .col_num2  (cur_num2),
        .column_lo (cube_lo),
        .column_hi (cube_hi)
    );

    boids_column_lookup #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) boids_column_lookup_inst (
        .col_num1  (cur_num1),
        .col_num2  (cur_num2),
        .boid_en   (boid_en),
        .boid_col  (boid_col),
        .boid_row  (boid_row),
        .column_lo (boids_lo),
        .column_hi (boids_hi)
    );

    always_ff @(posedge clk_in) begin
        if (rst) begin
            last_theta <= '0;
            scan_idx   <= '0;
            scan_done  <= 1'b0;
            col_valid  <= 1'b0;
        end else begin
            last_theta <= eff_theta;
            if (angle_changed) begin   // restart, a pending beat is abandoned
                scan_idx  <= '0;
                scan_done <= 1'b0;
                col_valid <= 1'b0;
            end else begin
                if (col_valid && col_ready) begin
                    col_valid <= 1'b0;
                end
                if (load) begin
                    col_valid <= 1'b1;
                end
                if (advance) begin
                    if (scan_idx == IDX_W'(SCAN_RATE - 1)) begin
                        scan_done <= 1'b1;   // idle until the angle moves
                    end else begin
                        scan_idx <= scan_idx + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (load && !angle_changed) begin
            column_lo <= (mode == mode_cube) ? cube_lo : boids_lo;
            column_hi <= (mode == mode_cube) ? cube_hi : boids_hi;
            col_num1  <= cur_num1;
            col_num2  <= cur_num2;
        end
    end

endmodule

`default_nettype wire

/* design/pov_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pov_top #(
    parameter int NUM_ROWS  = pov_geometry_pkg::default_num_rows_c,
    parameter int NUM_COLS  = pov_geometry_pkg::default_num_cols_c,
    parameter int SCAN_RATE = pov_geometry_pkg::default_scan_rate_c
) (
    input  logic                                       clk_in,
    input  logic                                       rst,
    input  logic [pov_geometry_pkg::theta_width_p-1:0] theta,
    input  logic                                       cfg_valid,
    input  logic [3:0]                                 cfg_addr,
    input  pov_display_pkg::cfg_word_u                 cfg_data,
    input  logic                                       col_ready,
    output logic                                       col_valid,
    output logic [NUM_ROWS-1:0]                        column_lo,
    output logic [NUM_ROWS-1:0]                        column_hi,
    output logic [$clog2(NUM_COLS)-1:0]                col_num1,
    output logic [$clog2(NUM_COLS)-1:0]                col_num2
);
    import pov_display_pkg::*;

    display_mode_e                mode;
    logic [7:0]                   theta_offset;
    logic [num_boids_c-1:0]       boid_en;
    logic [num_boids_c-1:0][4:0]  boid_col;
    logic [num_boids_c-1:0][3:0]  boid_row;

    pov_config_regs pov_config_regs_inst (
        .clk_in       (clk_in),
        .rst          (rst),
        .cfg_valid    (cfg_valid),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .mode         (mode),
        .theta_offset (theta_offset),
        .boid_en      (boid_en),
        .boid_col     (boid_col),
        .boid_row     (boid_row)
    );

    pov_frame_buffer #(
        .NUM_ROWS  (NUM_ROWS),
        .NUM_COLS  (NUM_COLS),
        .SCAN_RATE (SCAN_RATE)
    ) pov_frame_buffer_inst (
        .clk_in       (clk_in),
        .rst          (rst),
        .theta        (theta),
        .mode         (mode),
        .theta_offset (theta_offset),
        .boid_en      (boid_en),
        .boid_col     (boid_col),
        .boid_row     (boid_row),
        .col_ready    (col_ready),
        .col_valid    (col_valid),
        .column_lo    (column_lo),
        .column_hi    (column_hi),
        .col_num1     (col_num1),
        .col_num2     (col_num2)
    );

endmodule

`default_nettype wire

/* tb/pov_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module pov_assertions #(
    parameter int NUM_ROWS  = 16,
    parameter int NUM_COLS  = 32,
    parameter int SCAN_RATE = 16
) (
    input logic                        clk_in,
    input logic                        rst,
    input logic                        angle_changed,
    input logic                        col_valid,
    input logic                        col_ready,
    input logic [NUM_ROWS-1:0]         column_lo,
    input logic [NUM_ROWS-1:0]         column_hi,
    input logic [$clog2(NUM_COLS)-1:0] col_num1,
    input logic [$clog2(NUM_COLS)-1:0] col_num2
);
    localparam int COL_W = $clog2(NUM_COLS);

    int fail_count = 0;   // assertion failures so far

    // a stalled beat holds, unless an angle change abandons it
    hold_while_stalled: assert property (@(posedge clk_in) disable iff (rst)
        col_valid && !col_ready && !angle_changed |=>
            col_valid && $stable(column_lo) && $stable(column_hi) &&
            $stable(col_num1) && $stable(col_num2))
    else begin
        fail_count++;
        $error("column outputs changed while the beat was stalled");
    end

    column_pairing: assert property (@(posedge clk_in) disable iff (rst)
        col_valid |-> col_num2 == col_num1 + COL_W'(SCAN_RATE))
    else begin
        fail_count++;
        $error("col_num2 is not col_num1 plus the scan rate");
    end

    quiet_in_reset: assert property (@(posedge clk_in) rst |=> !col_valid)
    else begin
        fail_count++;
        $error("col_valid high during reset");
    end

endmodule

bind pov_frame_buffer pov_assertions #(
    .NUM_ROWS  (NUM_ROWS),
    .NUM_COLS  (NUM_COLS),
    .SCAN_RATE (SCAN_RATE)
) pov_assertions_inst (
    .clk_in        (clk_in),
    .rst           (rst),
    .angle_changed (angle_changed),
    .col_valid     (col_valid),
    .col_ready     (col_ready),
    .column_lo     (column_lo),
    .column_hi     (column_hi),
    .col_num1      (col_num1),
    .col_num2      (col_num2)
);

`default_nettype wire

/* tb/pov_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module pov_tb;
    import pov_geometry_pkg::*;
    import pov_display_pkg::*;

    localparam int    num_rows    = default_num_rows_c;
    localparam int    num_cols    = default_num_cols_c;
    localparam int    scan_rate   = default_scan_rate_c;
    localparam string vector_path = "tb/pov_vectors.txt";

    logic                        clk_in;
    logic                        rst;
    logic [7:0]                  theta;
    logic                        cfg_valid;
    logic [3:0]                  cfg_addr;
    cfg_word_u                   cfg_data;
    logic                        col_ready;
    logic                        col_valid;
    logic [num_rows-1:0]         column_lo;
    logic [num_rows-1:0]         column_hi;
    logic [$clog2(num_cols)-1:0] col_num1;
    logic [$clog2(num_cols)-1:0] col_num2;

    int                  exp_num[$];   // expected beats, oldest first
    logic [num_rows-1:0] exp_lo[$];
    logic [num_rows-1:0] exp_hi[$];
    bit                  exp_opt[$];   // beat of an angle that may be abandoned
    int                  pending;      // mandatory beats still in the queue
    int                  mismatches;
    int                  missing;
    int                  surplus;
    int                  bad_records;
    int                  assert_fails;
    int                  steps;
    bit                  steps_known;
    int                  fd;
    integer              seed;
    int                  ready_kind;   // 0 always ready, otherwise random
    int                  hold_cnt;     // cycles of forced low ready left
    int                  rnd;

    pov_top pov_top_inst (
        .clk_in    (clk_in),
        .rst       (rst),
        .theta     (theta),
        .cfg_valid (cfg_valid),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .col_ready (col_ready),
        .col_valid (col_valid),
        .column_lo (column_lo),
        .column_hi (column_hi),
        .col_num1  (col_num1),
        .col_num2  (col_num2)
    );

    always #10 clk_in = ~clk_in;

    always @(negedge clk_in) begin
        if (hold_cnt > 0) begin
            col_ready = 1'b0;
            hold_cnt--;
        end else if (ready_kind == 0) begin
            col_ready = 1'b1;
        end else begin
            rnd       = $random(seed);
            col_ready = rnd[0];
        end
    end

    always @(posedge clk_in) begin
        if (!rst && col_valid && col_ready) begin
            check_beat(col_num1, col_num2, column_lo, column_hi);
        end
    end

    task automatic drop_front();
        void'(exp_num.pop_front());
        void'(exp_lo.pop_front());
        void'(exp_hi.pop_front());
        void'(exp_opt.pop_front());
    endtask

    // beats of an abandoned angle can no longer arrive
    task automatic drop_leftovers();
        while (exp_num.size() > 0 && exp_opt[0]) begin
            drop_front();
        end
    endtask

    task automatic check_beat(input int num, input int num2, input logic [num_rows-1:0] lo,
                              input logic [num_rows-1:0] hi);
        int exp_num2;
        // leftovers of an abandoned angle are skipped until one matches
        while (exp_num.size() > 0 && exp_opt[0] &&
               !(exp_num[0] == num && exp_lo[0] == lo && exp_hi[0] == hi)) begin
            drop_front();
        end
        if (exp_num.size() == 0) begin
            surplus++;
            $display("%0t: beat for column %0d arrived when no beat was expected",
                     $time, num);
        end else begin
            if (!exp_opt[0]) begin
                pending--;
            end
            exp_num2 = exp_num[0] + scan_rate;   // second column of the beat
            if (exp_num[0] != num) begin
                mismatches++;
                $display("MISMATCH at %0t: col_num1 expected %0d, got %0d",
                         $time, exp_num[0], num);
            end
            if (exp_num2 != num2) begin
                mismatches++;
                $display("MISMATCH at %0t: col_num2 expected %0d, got %0d",
                         $time, exp_num2, num2);
            end
            if (exp_lo[0] !== lo) begin
                mismatches++;
                $display("MISMATCH at %0t: column_lo expected %h, got %h",
                         $time, exp_lo[0], lo);
            end
            if (exp_hi[0] !== hi) begin
                mismatches++;
                $display("MISMATCH at %0t: column_hi expected %h, got %h",
                         $time, exp_hi[0], hi);
            end
            drop_front();
        end
    endtask

    task automatic skip_line();
        int c;
        c = 0;
        while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // returns the letter of the next record, or -1 at end of file
    task automatic next_kind(output int kind);
        int c;
        kind = 0;
        while (kind == 0) begin
            c = $fgetc(fd);
            if (c == -1) begin
                kind = -1;
            end else if (c == "#") begin
                skip_line();
            end else if (c != " " && c != "\n" && c != "\t" && c != "\r") begin
                kind = c;
            end
        end
    endtask

    task automatic read_beats(input int n, output int mand);
        int                  kind;
        int                  num;
        logic [num_rows-1:0] lo;
        logic [num_rows-1:0] hi;
        int                  r;
        mand = 0;
        for (int k = 0; k < n; k++) begin
            next_kind(kind);
            r = $fscanf(fd, "%d %h %h", num, lo, hi);
            if (r != 3 || (kind != "b" && kind != "o")) begin
                bad_records++;
                $display("%0t: malformed beat record in the vector file", $time);
            end else begin
                exp_num.push_back(num);
                exp_lo.push_back(lo);
                exp_hi.push_back(hi);
                exp_opt.push_back(kind == "o");
                if (kind == "b") begin
                    mand++;
                    pending++;
                end
            end
        end
    endtask

    task automatic wait_for_beats(input int mand);
        if (mand > 0) begin
            while (pending > 0) begin
                @(negedge clk_in);
            end
            repeat (scan_rate + 2) @(negedge clk_in);   // room for surplus beats
        end else begin
            repeat (3) @(negedge clk_in);
        end
    endtask

    task automatic count_steps();
        int c;
        int prev;
        int cfd;
        cfd  = $fopen(vector_path, "r");
        prev = "\n";
        if (cfd != 0) begin
            c = $fgetc(cfd);
            while (c != -1) begin
                if (c == "A" && prev == "\n") begin
                    steps++;
                end
                prev = c;
                c    = $fgetc(cfd);
            end
            $fclose(cfd);
        end
        steps_known = 1'b1;
    endtask

    initial begin
        int limit;
        wait (steps_known);
        limit = 10 + steps * (scan_rate + 4) * 8;
        repeat (limit) @(posedge clk_in);
        $display("watchdog expired after %0d cycles, the run did not complete", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int kind;
        int a;
        int b;
        int n;
        int mand;
        bit done;
        clk_in     = 1'b0;
        rst        = 1'b1;
        theta      = '0;
        cfg_valid  = 1'b0;
        cfg_addr   = '0;
        cfg_data   = '0;
        col_ready  = 1'b0;
        seed       = 32'h975cdfbf;
        ready_kind = 0;
        hold_cnt   = 0;
        pending    = 0;
        mismatches = 0;
        missing    = 0;
        surplus    = 0;
        bad_records = 0;
        steps      = 0;
        done       = 1'b0;
        count_steps();
        fd = $fopen(vector_path, "r");
        if (fd == 0) begin
            bad_records++;
            $display("could not open the vector file %s", vector_path);
            done = 1'b1;
        end
        repeat (10) @(posedge clk_in);
        @(negedge clk_in);
        rst = 1'b0;
        while (!done) begin
            next_kind(kind);
            if (kind == -1) begin
                done = 1'b1;
            end else if (kind == "R") begin
                if ($fscanf(fd, "%d %d", a, b) != 2) begin
                    bad_records++;
                    $display("%0t: malformed ready record in the vector file", $time);
                end
                ready_kind = (a == 0) ? 0 : 1;
                if (a == 2) begin
                    hold_cnt = b;   // long stall, then random
                end
            end else if (kind == "W") begin
                if ($fscanf(fd, "%h %h %d", a, b, n) != 3) begin
                    bad_records++;
                    $display("%0t: malformed write record, reading stopped", $time);
                    done = 1'b1;
                end else begin
                    read_beats(n, mand);
                    cfg_valid = 1'b1;
                    cfg_addr  = a[3:0];
                    cfg_data  = b[15:0];
                    @(negedge clk_in);
                    cfg_valid = 1'b0;
                    wait_for_beats(mand);
                end
            end else if (kind == "A") begin
                if ($fscanf(fd, "%d %d", a, n) != 2) begin
                    bad_records++;
                    $display("%0t: malformed angle record, reading stopped", $time);
                    done = 1'b1;
                end else begin
                    theta = a[7:0];
                    @(negedge clk_in);   // the old scan is abandoned at this edge
                    drop_leftovers();
                    read_beats(n, mand);
                    wait_for_beats(mand);
                end
            end else begin
                bad_records++;
                $display("%0t: unknown record type in the vector file", $time);
                skip_line();
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        while (exp_num.size() > 0) begin
            if (!exp_opt[0]) begin
                missing++;
                $display("%0t: expected beat for column %0d never arrived", $time, exp_num[0]);
            end
            drop_front();
        end
        assert_fails = pov_top_inst.pov_frame_buffer_inst.pov_assertions_inst.fail_count;
        $display("errors: mismatch %0d, missing %0d, surplus %0d, record %0d, assert %0d",
                 mismatches, missing, surplus, bad_records, assert_fails);
        if (mismatches + missing + surplus + bad_records + assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/pov_vectors.txt */
# R kind len (0 ready, 1 random, 2 low for len then random) | W addr data beats | A theta beats
# beats: b (required) or o (optional) col_num1 column_lo column_hi, words in hex
R 0 0
A 0 11
b 0 0000 0000 b 1 0000 0000 b 2 0000 0000 b 4 0000 0000
b 5 0000 0000 b 7 0000 0000 b 9 0000 0000 b 10 0000 0000
b 12 0000 0000 b 14 0000 0000 b 15 0000 0000
# cube mode, one angle per quadrant, random and long-held ready
W 0 0100 0
R 1 0
A 32 10
b 0 0000 0820 b 2 0000 0820 b 4 0000 0000 b 5 0000 0000 b 7 0000 0000
b 8 0000 0000 b 10 0000 0000 b 12 0000 0000 b 13 0fe0 0000 b 15 0820 0000
A 64 10
b 0 0000 1010 b 2 0000 1010 b 3 0000 1010 b 5 0000 0000 b 7 0000 0000
b 8 0000 0000 b 10 0000 0000 b 12 1ff0 0000 b 13 1010 0000 b 15 1010 0000
R 2 40
A 128 10
b 0 0000 2008 b 1 0000 2008 b 3 0000 2008 b 5 0000 3ff8 b 6 0000 0000
b 8 0000 0000 b 9 0000 0000 b 11 3ff8 0000 b 13 2008 0000 b 14 2008 0000
A 200 10
b 1 0000 4004 b 2 0000 4004 b 3 0000 4004 b 4 0000 4004 b 6 0000 7ffc
b 7 0000 0000 b 9 0000 0000 b 11 4004 0000 b 12 4004 0000 b 14 4004 0000
# offset 56 turns angle 200 into 0
W 0 0138 11
b 0 0000 0820 b 1 0000 0820 b 2 0000 0820 b 4 0000 0000 b 5 0000 0000
b 7 0000 0000 b 9 0000 0000 b 10 0000 0000 b 12 0000 0000 b 14 0820 0000
b 15 0820 0000
# boids mode, offset kept, two boids in column 2 and slot 3 disabled
W 0 0038 0
W 1 2230 0
W 2 2290 0
W 3 34f0 0
W 4 0d00 0
W 5 3f70 0
A 232 10
b 0 0000 0000 b 2 0208 0000 b 4 0000 8000 b 5 0000 0000 b 7 0000 0000
b 8 0000 0000 b 10 0000 0000 b 12 0000 0000 b 13 0000 0000 b 15 0000 0080
# angle abandoned after a few cycles
A 200 5
o 0 0000 0000 o 1 0000 0000 o 2 0208 0000 o 4 0000 8000 o 5 0000 0000
A 8 10
b 0 0000 0000 b 2 0208 0000 b 3 0000 0000 b 5 0000 0000 b 7 0000 0000
b 8 0000 0000 b 10 0000 0000 b 12 0000 0000 b 13 0000 0000 b 15 0000 0080

/* compile.f */
design/pov_geometry_pkg.sv
design/pov_display_pkg.sv
design/pov_config_regs.sv
design/scan_mask_calc.sv
design/cube_column_gen.sv
design/boids_column_lookup.sv
design/pov_frame_buffer.sv
design/pov_top.sv
tb/pov_assertions.sv
tb/pov_tb.sv

/* Bender.yml */
package:
  name: pov_display

sources:
  - files:
      - design/pov_geometry_pkg.sv
      - design/pov_display_pkg.sv
      - design/pov_config_regs.sv
      - design/scan_mask_calc.sv
      - design/cube_column_gen.sv
      - design/boids_column_lookup.sv
      - design/pov_frame_buffer.sv
      - design/pov_top.sv
  - target: test
    files:
      - tb/pov_assertions.sv
      - tb/pov_tb.sv
